//--- fetch_pkg.sv
package fetch_pkg;

    localparam int unsigned XLEN = 64;
    localparam int unsigned ILEN = 32;

    // address and data width of the core
    typedef logic [XLEN-1:0] xlen_t;
    // one uncompressed instruction word
    typedef logic [ILEN-1:0] inst_t;

    // control transfer request from execute and csr side
    typedef struct packed {
        logic  jal;
        logic  jalr;
        logic  branch;
        logic  trap;
        xlen_t pc;
        xlen_t imm;
        xlen_t r1data;
        xlen_t alu_res;
        xlen_t mtvec;
    } redirect_t;

    // fetched instruction handed to decode
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetch_out_t;

    // read address channel, master side
    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } rd_req_t;

    // read data channel, one 64-bit beat per read
    typedef struct packed {
        logic  valid;
        xlen_t data;
    } rd_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } bus_state_e;

endpackage

//--- fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen #(
    parameter fetch_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  fetch_pkg::redirect_t redirect_i,
    input  logic                 stall_i,
    input  logic                 pc_done_i,
    output fetch_pkg::xlen_t     pc_o,
    output logic                 redirect_taken_o
);

    fetch_pkg::xlen_t pc_q;
    fetch_pkg::xlen_t pc_d;
    fetch_pkg::xlen_t jal_target;
    fetch_pkg::xlen_t jalr_sum;
    fetch_pkg::xlen_t jalr_target;
    logic             take_jal;
    logic             advance;
    logic             adv_pend_q;

    // jal and taken branch share one adder
    assign take_jal    = redirect_i.jal | (redirect_i.branch & (redirect_i.alu_res == '0));
    assign jal_target  = redirect_i.pc + redirect_i.imm;
    assign jalr_sum    = redirect_i.r1data + redirect_i.imm;
    assign jalr_target = {jalr_sum[fetch_pkg::XLEN-1:1], 1'b0};

    assign redirect_taken_o = take_jal | redirect_i.jalr | redirect_i.trap;

    // a completion seen under stall is kept until the stall drops
    assign advance = (pc_done_i | adv_pend_q) & ~stall_i;

    always_comb begin
        pc_d = pc_q;
        if (take_jal) begin
            pc_d = jal_target;
        end else if (redirect_i.jalr) begin
            pc_d = jalr_target;
        end else if (redirect_i.trap) begin
            pc_d = redirect_i.mtvec;
        end else if (advance) begin
            pc_d = pc_q + fetch_pkg::xlen_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            adv_pend_q <= 1'b0;
        end else begin
            pc_q <= pc_d;
            // a redirect makes any pending step meaningless
            if (redirect_taken_o || advance) begin
                adv_pend_q <= 1'b0;
            end else if (pc_done_i) begin
                adv_pend_q <= 1'b1;
            end
        end
    end

    assign pc_o = pc_q;

endmodule

//--- fetch_bus_ctrl.sv
`timescale 1ns/100ps

module fetch_bus_ctrl (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fetch_pkg::xlen_t      pc_i,
    input  logic                  redirect_taken_i,
    input  logic                  stall_i,
    output fetch_pkg::rd_req_t    rd_req_o,
    input  logic                  rd_addr_ready_i,
    input  fetch_pkg::rd_rsp_t    rd_rsp_i,
    output logic                  rd_data_ready_o,
    output logic                  pc_done_o,
    output fetch_pkg::fetch_out_t fetch_o
);

    fetch_pkg::bus_state_e state_q;
    fetch_pkg::bus_state_e state_d;
    fetch_pkg::xlen_t      addr_q;
    logic                  stale_q;
    logic                  addr_fire;
    logic                  rsp_fire;
    logic                  drop_rsp;
    fetch_pkg::inst_t      word_sel;
    logic                  out_valid_q;
    fetch_pkg::xlen_t      out_pc_q;
    fetch_pkg::inst_t      out_inst_q;

    // channel handshakes
    assign addr_fire = rd_req_o.valid & rd_addr_ready_i;
    assign rsp_fire  = rd_rsp_i.valid & rd_data_ready_o;

    // address and valid stay put from ADDR entry until the transfer
    assign rd_req_o.valid  = (state_q == fetch_pkg::ADDR);
    assign rd_req_o.addr   = addr_q;
    assign rd_data_ready_o = (state_q == fetch_pkg::DATA);

    // response is thrown away if the pc moved on while it was in flight
    assign drop_rsp = stale_q | redirect_taken_i | (pc_i != addr_q);

    assign pc_done_o = rsp_fire & ~drop_rsp;

    // bit 2 picks the word within the 64-bit beat
    assign word_sel = addr_q[2] ? rd_rsp_i.data[63:32] : rd_rsp_i.data[31:0];

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            fetch_pkg::IDLE: begin
                if (!stall_i) begin
                    state_d = fetch_pkg::ADDR;
                end
            end
            fetch_pkg::ADDR: begin
                if (addr_fire) begin
                    state_d = fetch_pkg::DATA;
                end
            end
            fetch_pkg::DATA: begin
                if (rsp_fire) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: begin
                state_d = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= fetch_pkg::IDLE;
            stale_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            out_valid_q <= pc_done_o;
            // stale only lives for the read in flight
            if (state_q == fetch_pkg::IDLE || rsp_fire) begin
                stale_q <= 1'b0;
            end else if (redirect_taken_i) begin
                stale_q <= 1'b1;
            end
        end
    end

    // request address, captured when a new read starts
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::IDLE && !stall_i) begin
            addr_q <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_done_o) begin
            out_pc_q   <= addr_q;
            out_inst_q <= word_sel;
        end
    end

    assign fetch_o.valid = out_valid_q;
    assign fetch_o.pc    = out_pc_q;
    assign fetch_o.inst  = out_inst_q;

endmodule

//--- fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
    parameter fetch_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  stall_i,
    output fetch_pkg::rd_req_t    rd_req_o,
    input  logic                  rd_addr_ready_i,
    input  fetch_pkg::rd_rsp_t    rd_rsp_i,
    output logic                  rd_data_ready_o,
    output fetch_pkg::fetch_out_t fetch_o
);

    fetch_pkg::xlen_t pc;
    logic             redirect_taken;
    logic             pc_done;

    // pc register and redirect mux
    fetch_pc_gen #(
        .RESET_PC(RESET_PC)
    ) i_pc_gen (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .stall_i         (stall_i),
        .pc_done_i       (pc_done),
        .pc_o            (pc),
        .redirect_taken_o(redirect_taken)
    );

    // one outstanding read at a time
    fetch_bus_ctrl i_bus_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc),
        .redirect_taken_i(redirect_taken),
        .stall_i         (stall_i),
        .rd_req_o        (rd_req_o),
        .rd_addr_ready_i (rd_addr_ready_i),
        .rd_rsp_i        (rd_rsp_i),
        .rd_data_ready_o (rd_data_ready_o),
        .pc_done_o       (pc_done),
        .fetch_o         (fetch_o)
    );

endmodule

//--- tb_fetch_mem.sv
`timescale 1ns/100ps

module tb_fetch_mem (
    input  logic               clk,
    input  logic               rst_n_i,
    input  fetch_pkg::rd_req_t rd_req_i,
    output logic               rd_addr_ready_o,
    output fetch_pkg::rd_rsp_t rd_rsp_o,
    input  logic               rd_data_ready_i
);

    integer seed;

    // word at an aligned address
    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::xlen_t addr);
        return addr[31:0] ^ 32'h1300_0000;
    endfunction

    // both words of the 8-byte line holding addr
    function automatic fetch_pkg::xlen_t mem_beat(input fetch_pkg::xlen_t addr);
        fetch_pkg::xlen_t base;
        base = {addr[63:3], 3'b000};
        return {mem_word(base | 64'h4), mem_word(base)};
    endfunction

    function automatic int random_delay();
        return {$random(seed)} % 4;
    endfunction

    // one read, address phase then data phase
    task automatic serve_read();
        fetch_pkg::xlen_t addr;
        int               tries;
        addr = rd_req_i.addr;
        repeat (random_delay()) @(posedge clk);
        rd_addr_ready_o <= 1'b1;
        // valid is held, so the address transfers on this edge
        @(posedge clk);
        rd_addr_ready_o <= 1'b0;
        repeat (random_delay()) @(posedge clk);
        rd_rsp_o <= {1'b1, mem_beat(addr)};
        tries = 0;
        do begin
            @(posedge clk);
            tries++;
        end while (!rd_data_ready_i && tries < 200);
        rd_rsp_o <= '0;
    endtask

    initial begin
        seed            = 21;
        rd_addr_ready_o = 1'b0;
        rd_rsp_o        = '0;
        forever begin
            @(posedge clk);
            if (rst_n_i && rd_req_i.valid) begin
                serve_read();
            end
        end
    end

endmodule

//--- tb_fetch.sv
`timescale 1ns/100ps

module tb_fetch;

    localparam fetch_pkg::xlen_t RESET_PC   = 64'h0000_0000_8000_0000;
    localparam int               WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst_n;
    fetch_pkg::redirect_t  redirect;
    logic                  stall;
    fetch_pkg::rd_req_t    rd_req;
    logic                  rd_addr_ready;
    fetch_pkg::rd_rsp_t    rd_rsp;
    logic                  rd_data_ready;
    fetch_pkg::fetch_out_t fetch_out;

    int               errors;
    int               checks;
    int               fd;
    int               n;
    int               test_no;
    int               errors_before;
    logic             aborted;
    logic             done;
    logic [63:0]      cmd;
    logic [63:0]      count;
    logic [8*200-1:0] rest;
    fetch_pkg::xlen_t op_pc;
    fetch_pkg::xlen_t op_imm;
    fetch_pkg::xlen_t op_r1;
    fetch_pkg::xlen_t op_alu;
    fetch_pkg::xlen_t op_mtvec;
    fetch_pkg::xlen_t exp_pc;

    fetch_top #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .redirect_i     (redirect),
        .stall_i        (stall),
        .rd_req_o       (rd_req),
        .rd_addr_ready_i(rd_addr_ready),
        .rd_rsp_i       (rd_rsp),
        .rd_data_ready_o(rd_data_ready),
        .fetch_o        (fetch_out)
    );

    tb_fetch_mem i_mem (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .rd_req_i       (rd_req),
        .rd_addr_ready_o(rd_addr_ready),
        .rd_rsp_o       (rd_rsp),
        .rd_data_ready_i(rd_data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // low word of the address xor a fixed opcode
    function automatic fetch_pkg::inst_t expected_word(input fetch_pkg::xlen_t addr);
        return addr[31:0] ^ 32'h1300_0000;
    endfunction

    task automatic check_pc(input fetch_pkg::xlen_t got, input fetch_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: fetch pc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: fetch inst %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_req(input fetch_pkg::rd_req_t got, input fetch_pkg::rd_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: read request %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %0s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // all strobes low out of reset, then the first request on the next edge
    task automatic check_reset();
        fetch_pkg::rd_req_t exp_req;
        exp_req       = '0;
        exp_req.valid = 1'b1;
        exp_req.addr  = RESET_PC;
        @(negedge clk);
        check_flag("rd_req_o.valid", rd_req.valid, 1'b0);
        check_flag("rd_data_ready_o", rd_data_ready, 1'b0);
        check_flag("fetch_o.valid", fetch_out.valid, 1'b0);
        @(negedge clk);
        check_req(rd_req, exp_req);
    endtask

    task automatic check_fetch();
        check_pc(fetch_out.pc, exp_pc);
        check_inst(fetch_out.inst, expected_word(exp_pc));
        exp_pc = exp_pc + 64'd4;
    endtask

    // sampled on the falling edge where the outputs are settled
    task automatic expect_fetch();
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            got = fetch_out.valid;
        end
        if (got) begin
            check_fetch();
        end else begin
            errors++;
            aborted = 1'b1;
            $display("timeout: fetch_o.valid never came for pc %h", exp_pc);
        end
    endtask

    // the read already issued may still complete but nothing beyond it
    task automatic stall_cycles(input int cycles);
        int seen;
        seen = 0;
        @(posedge clk);
        stall <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (fetch_out.valid) begin
                seen++;
                if (seen > 1) begin
                    errors++;
                    $display("FAILED at time %0t: new fetch during stall, pc %h",
                             $time, fetch_out.pc);
                end else begin
                    check_fetch();
                end
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        if (seen == 0) begin
            expect_fetch();
        end
    endtask

    task automatic issue_redirect();
        fetch_pkg::redirect_t req;
        req         = '0;
        req.pc      = op_pc;
        req.imm     = op_imm;
        req.r1data  = op_r1;
        req.alu_res = op_alu;
        req.mtvec   = op_mtvec;
        req.jal     = (cmd == "jal") || (cmd == "jaltrap");
        req.branch  = (cmd == "branch");
        req.jalr    = (cmd == "jalr");
        req.trap    = (cmd == "trap") || (cmd == "jaltrap");
        @(posedge clk);
        redirect <= req;
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic run_command();
        if (cmd == "run") begin
            repeat (int'(count)) begin
                if (!aborted) begin
                    expect_fetch();
                end
            end
        end else if (cmd == "stall") begin
            stall_cycles(int'(count));
        end else if (cmd == "jal" || cmd == "branch" || cmd == "jalr" ||
                     cmd == "trap" || cmd == "jaltrap") begin
            issue_redirect();
            expect_fetch();
        end else begin
            errors++;
            aborted = 1'b1;
            $display("unknown command %0s in fetch_golden.txt", cmd);
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        test_no  = 0;
        aborted  = 1'b0;
        done     = 1'b0;
        rst_n    = 1'b0;
        stall    = 1'b0;
        redirect = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_no++;
        errors_before = errors;
        check_reset();
        $display("test %0d reset: %0d error(s)", test_no, errors - errors_before);
        fd = $fopen("fetch_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            done = 1'b1;
            $display("could not open fetch_golden.txt");
        end
        while (!done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h",
                            count, op_pc, op_imm, op_r1, op_alu, op_mtvec, exp_pc);
                if (n != 7) begin
                    errors++;
                    done = 1'b1;
                    $display("malformed line in fetch_golden.txt after test %0d", test_no);
                end else begin
                    test_no++;
                    errors_before = errors;
                    run_command();
                    $display("test %0d %0s: %0d error(s)", test_no, cmd,
                             errors - errors_before);
                    done = aborted;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- fetch_golden.txt
# columns: cmd count pc imm r1data alu_res mtvec expected_pc, numbers in hex
# count is instructions for run and cycles for stall, expected_pc is the next fetch
run 6 0 0 0 0 0 80000000
jal 0 80000014 100 0 0 0 80000114
run 3 0 0 0 0 0 80000118
branch 0 80000120 ffffffffffffffe0 0 0 0 80000100
run 2 0 0 0 0 0 80000104
branch 0 80000108 40 0 5 0 8000010c
run 2 0 0 0 0 0 80000110
jalr 0 80000114 10 80002001 0 0 80002010
run 3 0 0 0 0 0 80002014
stall 0a 0 0 0 0 0 80002020
run 3 0 0 0 0 0 80002024
trap 0 0 0 0 0 80000400 80000400
run 2 0 0 0 0 0 80000404
jaltrap 0 80000408 200 0 0 80000400 80000608
run 2 0 0 0 0 0 8000060c
stall 3 0 0 0 0 0 80000614
run 4 0 0 0 0 0 80000618
jalr 0 80000624 1 80000700 0 0 80000700
run 3 0 0 0 0 0 80000704
trap 0 0 0 0 0 1000000040 1000000040
run 3 0 0 0 0 0 1000000044
branch 0 100000004c 7ffc 0 0 0 1000008048
run 2 0 0 0 0 0 100000804c
stall 6 0 0 0 0 0 1000008054
run 2 0 0 0 0 0 1000008058

//--- compile.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_bus_ctrl.sv
fetch_top.sv
tb_fetch_mem.sv
tb_fetch.sv

//--- Bender.yml
package:
  name: fetch

sources:
  - fetch_pkg.sv
  - fetch_pc_gen.sv
  - fetch_bus_ctrl.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_mem.sv
      - tb_fetch.sv
